//--- all.f
+incdir+.
core_pkg.sv
id_ex_if.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
core_top.sv
tb_core.sv

//--- run.sh
#!/bin/sh
set -e

verilator --binary --timing --timescale 1ns/1ps -f all.f --top-module tb_core \
    --Mdir obj_dir -o tb_core_sim
./obj_dir/tb_core_sim > sim.log 2>&1
cat sim.log

if grep -qF '*** PASSED ***' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- tb_core.sv
`default_nettype none

module tb_core;
    timeunit 1ns;
    timeprecision 1ps;

    import core_pkg::*;

    localparam int     RETIRE_TIMEOUT = 50;
    localparam instr_t NOP = 32'h0000_0013;

    localparam int GRP_RESET  = 0;
    localparam int GRP_ALU    = 1;
    localparam int GRP_FWD    = 2;
    localparam int GRP_BRANCH = 3;
    localparam int GRP_JUMP   = 4;
    localparam int GRP_X0     = 5;
    localparam int NUM_GRPS   = 6;

    logic     clk_i;
    logic     rst_ni;
    addr_t    imem_addr_o;
    instr_t   imem_data_i;
    addr_t    pc_debug_o;
    logic     insn_vld_o;
    logic     wb_wren_o;
    reg_idx_t wb_rd_o;
    word_t    wb_data_o;

    // Program image, one word per instruction from address 0
    instr_t prog_mem [64];
    int     prog_len;
    logic   prog_ready;

    // Expected retire events in program order
    addr_t    exp_pc [$];
    logic     exp_wren [$];
    reg_idx_t exp_rd [$];
    word_t    exp_data [$];
    int       exp_grp [$];

    string grp_name [NUM_GRPS] = '{"reset", "alu", "forwarding", "branch", "jump", "x0"};
    int    grp_fail [NUM_GRPS];
    int    pass_cnt;
    int    fail_cnt;

    core_top dut (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .imem_addr_o (imem_addr_o),
        .imem_data_i (imem_data_i),
        .pc_debug_o  (pc_debug_o),
        .insn_vld_o  (insn_vld_o),
        .wb_wren_o   (wb_wren_o),
        .wb_rd_o     (wb_rd_o),
        .wb_data_o   (wb_data_o)
    );

    always #5 clk_i = ~clk_i;

    // Instruction memory, answers in the same cycle
    always_comb begin
        if (prog_ready && (imem_addr_o[1:0] == 2'b00) &&
            ((imem_addr_o >> 2) < addr_t'(prog_len))) begin
            imem_data_i = prog_mem[imem_addr_o[7:2]];
        end else begin
            imem_data_i = NOP;
        end
    end

    function automatic instr_t r_type(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
    endfunction

    function automatic instr_t i_type(int imm, int rs1, int f3, int rd, opcode_e opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic instr_t u_type(int imm, int rd, opcode_e opc);
        return {imm[19:0], rd[4:0], opc};
    endfunction

    function automatic instr_t b_type(int off, int rs2, int rs1, int f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                OPC_BRANCH};
    endfunction

    function automatic instr_t j_type(int off, int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
    endfunction

    // Appends one word and, if it retires, its expected write-back
    task automatic add_insn(instr_t word, int ret, int wren, int rd, word_t data, int grp);
        addr_t pc;
        pc = addr_t'(prog_len * 4);
        prog_mem[prog_len[5:0]] = word;
        prog_len++;
        if (ret != 0) begin
            exp_pc.push_back(pc);
            exp_wren.push_back(wren != 0);
            exp_rd.push_back(reg_idx_t'(rd));
            exp_data.push_back(data);
            exp_grp.push_back(grp);
        end
    endtask

    // Columns: word, retires, writes rd, rd, value, group
    task automatic load_program();
        add_insn(i_type(5, 0, 0, 1, OPC_OP_IMM), 1, 1, 1, 32'h0000_0005, GRP_RESET); // 00 addi
        add_insn(i_type(-3, 0, 0, 2, OPC_OP_IMM), 1, 1, 2, 32'hFFFF_FFFD, GRP_ALU);  // 04 addi
        add_insn(r_type(0, 2, 1, 0, 3), 1, 1, 3, 32'h0000_0002, GRP_ALU);            // 08 add
        add_insn(r_type(32, 2, 1, 0, 4), 1, 1, 4, 32'h0000_0008, GRP_ALU);           // 0c sub
        add_insn(r_type(0, 2, 1, 4, 5), 1, 1, 5, 32'hFFFF_FFF8, GRP_ALU);            // 10 xor
        add_insn(r_type(0, 2, 1, 6, 6), 1, 1, 6, 32'hFFFF_FFFD, GRP_ALU);            // 14 or
        add_insn(r_type(0, 2, 1, 7, 7), 1, 1, 7, 32'h0000_0005, GRP_ALU);            // 18 and
        add_insn(i_type(4, 1, 1, 8, OPC_OP_IMM), 1, 1, 8, 32'h0000_0050, GRP_ALU);   // 1c slli
        add_insn(i_type(28, 2, 5, 9, OPC_OP_IMM), 1, 1, 9, 32'h0000_000F, GRP_ALU);  // 20 srli
        add_insn(i_type(32'h401, 2, 5, 10, OPC_OP_IMM), 1, 1, 10, 32'hFFFF_FFFE, GRP_ALU); // srai
        add_insn(r_type(0, 1, 2, 2, 11), 1, 1, 11, 32'h0000_0001, GRP_ALU);          // 28 slt
        add_insn(r_type(0, 1, 2, 3, 12), 1, 1, 12, 32'h0000_0000, GRP_ALU);          // 2c sltu
        add_insn(u_type(32'h12345, 13, OPC_LUI), 1, 1, 13, 32'h1234_5000, GRP_ALU);  // 30 lui
        add_insn(u_type(1, 14, OPC_AUIPC), 1, 1, 14, 32'h0000_1034, GRP_ALU);        // 34 auipc
        add_insn(i_type(7, 0, 0, 16, OPC_OP_IMM), 1, 1, 16, 32'h0000_0007, GRP_FWD); // 38 addi
        add_insn(i_type(1, 16, 0, 17, OPC_OP_IMM), 1, 1, 17, 32'h0000_0008, GRP_FWD); // 3c
        add_insn(r_type(0, 17, 16, 0, 18), 1, 1, 18, 32'h0000_000F, GRP_FWD);        // 40 add
        add_insn(r_type(0, 18, 16, 0, 19), 1, 1, 19, 32'h0000_0016, GRP_FWD);        // 44 add
        add_insn(r_type(32, 17, 19, 0, 20), 1, 1, 20, 32'h0000_000E, GRP_FWD);       // 48 sub
        add_insn(r_type(0, 20, 20, 0, 21), 1, 1, 21, 32'h0000_001C, GRP_FWD);        // 4c add
        add_insn(i_type(1, 0, 0, 22, OPC_OP_IMM), 1, 1, 22, 32'h1, GRP_BRANCH);      // 50 addi
        add_insn(b_type(12, 1, 22, 0), 1, 0, 0, 32'h0, GRP_BRANCH);                  // 54 beq nt
        add_insn(b_type(12, 1, 22, 1), 1, 0, 0, 32'h0, GRP_BRANCH);                  // 58 bne t
        add_insn(i_type(99, 0, 0, 23, OPC_OP_IMM), 0, 0, 0, 32'h0, GRP_BRANCH);      // 5c
        add_insn(i_type(98, 0, 0, 23, OPC_OP_IMM), 0, 0, 0, 32'h0, GRP_BRANCH);      // 60
        add_insn(i_type(3, 0, 0, 23, OPC_OP_IMM), 1, 1, 23, 32'h3, GRP_BRANCH);      // 64 addi
        add_insn(b_type(12, 1, 2, 4), 1, 0, 0, 32'h0, GRP_BRANCH);                   // 68 blt t
        add_insn(i_type(99, 0, 0, 24, OPC_OP_IMM), 0, 0, 0, 32'h0, GRP_BRANCH);      // 6c
        add_insn(i_type(98, 0, 0, 24, OPC_OP_IMM), 0, 0, 0, 32'h0, GRP_BRANCH);      // 70
        add_insn(b_type(12, 1, 2, 6), 1, 0, 0, 32'h0, GRP_BRANCH);                   // 74 bltu nt
        add_insn(b_type(12, 1, 2, 5), 1, 0, 0, 32'h0, GRP_BRANCH);                   // 78 bge nt
        add_insn(b_type(12, 1, 2, 7), 1, 0, 0, 32'h0, GRP_BRANCH);                   // 7c bgeu t
        add_insn(i_type(99, 0, 0, 24, OPC_OP_IMM), 0, 0, 0, 32'h0, GRP_BRANCH);      // 80
        add_insn(i_type(98, 0, 0, 24, OPC_OP_IMM), 0, 0, 0, 32'h0, GRP_BRANCH);      // 84
        add_insn(i_type(4, 0, 0, 24, OPC_OP_IMM), 1, 1, 24, 32'h4, GRP_BRANCH);      // 88 addi
        add_insn(j_type(12, 25), 1, 1, 25, 32'h0000_0090, GRP_JUMP);                 // 8c jal
        add_insn(i_type(99, 0, 0, 26, OPC_OP_IMM), 0, 0, 0, 32'h0, GRP_JUMP);        // 90
        add_insn(i_type(98, 0, 0, 26, OPC_OP_IMM), 0, 0, 0, 32'h0, GRP_JUMP);        // 94
        add_insn(i_type(32'hA9, 0, 0, 26, OPC_OP_IMM), 1, 1, 26, 32'hA9, GRP_JUMP);  // 98 addi
        add_insn(i_type(0, 26, 0, 27, OPC_JALR), 1, 1, 27, 32'h0000_00A0, GRP_JUMP); // 9c jalr
        add_insn(i_type(99, 0, 0, 27, OPC_OP_IMM), 0, 0, 0, 32'h0, GRP_JUMP);        // a0
        add_insn(i_type(98, 0, 0, 27, OPC_OP_IMM), 0, 0, 0, 32'h0, GRP_JUMP);        // a4
        add_insn(i_type(1, 27, 0, 28, OPC_OP_IMM), 1, 1, 28, 32'hA1, GRP_JUMP);      // a8 addi
        add_insn(i_type(55, 0, 0, 0, OPC_OP_IMM), 1, 0, 0, 32'h0, GRP_X0);           // ac addi x0
        add_insn(r_type(0, 0, 0, 0, 29), 1, 1, 29, 32'h0, GRP_X0);                   // b0 add
        add_insn(u_type(32'hFFFFF, 0, OPC_LUI), 1, 0, 0, 32'h0, GRP_X0);             // b4 lui x0
        add_insn(r_type(0, 0, 1, 0, 30), 1, 1, 30, 32'h5, GRP_X0);                   // b8 add
    endtask

    task automatic wait_retire(output logic seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && (cycles < RETIRE_TIMEOUT)) begin
            @(negedge clk_i);
            cycles++;
            if (insn_vld_o) begin
                seen = 1'b1;
            end
        end
    endtask

    initial begin
        logic seen;
        logic aborted;
        int   k;
        int   g;
        clk_i      = 1'b0;
        rst_ni     = 1'b0;
        prog_ready = 1'b0;
        prog_len   = 0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        aborted    = 1'b0;
        load_program();
        prog_ready = 1'b1;

        // Nothing retires while reset is held
        for (k = 0; k < 10; k++) begin
            @(negedge clk_i);
            if (insn_vld_o !== 1'b0) begin
                $display("Mismatch at %0d ns: insn_vld_o expected 0, got %b", $time, insn_vld_o);
                fail_cnt++;
                grp_fail[GRP_RESET]++;
            end else begin
                pass_cnt++;
            end
            if (wb_wren_o !== 1'b0) begin
                $display("Mismatch at %0d ns: wb_wren_o expected 0, got %b", $time, wb_wren_o);
                fail_cnt++;
                grp_fail[GRP_RESET]++;
            end else begin
                pass_cnt++;
            end
        end
        @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        for (k = 0; (k < exp_pc.size()) && !aborted; k++) begin
            g = exp_grp[k];
            wait_retire(seen);
            if (!seen) begin
                $display("Instruction at pc %h never retired within %0d cycles",
                         exp_pc[k], RETIRE_TIMEOUT);
                fail_cnt++;
                grp_fail[g]++;
                aborted = 1'b1;
            end else begin
                if (pc_debug_o !== exp_pc[k]) begin
                    $display("Mismatch at %0d ns: pc_debug_o expected %h, got %h",
                             $time, exp_pc[k], pc_debug_o);
                    fail_cnt++;
                    grp_fail[g]++;
                end else begin
                    pass_cnt++;
                end
                if (wb_wren_o !== exp_wren[k]) begin
                    $display("Mismatch at %0d ns: wb_wren_o expected %b, got %b",
                             $time, exp_wren[k], wb_wren_o);
                    fail_cnt++;
                    grp_fail[g]++;
                end else begin
                    pass_cnt++;
                end
                // Index and value only mean something for a writer
                if (exp_wren[k] && (wb_rd_o !== exp_rd[k])) begin
                    $display("Mismatch at %0d ns: wb_rd_o expected %0d, got %0d",
                             $time, exp_rd[k], wb_rd_o);
                    fail_cnt++;
                    grp_fail[g]++;
                end else if (exp_wren[k]) begin
                    pass_cnt++;
                end
                if (exp_wren[k] && (wb_data_o !== exp_data[k])) begin
                    $display("Mismatch at %0d ns: wb_data_o expected %h, got %h",
                             $time, exp_data[k], wb_data_o);
                    fail_cnt++;
                    grp_fail[g]++;
                end else if (exp_wren[k]) begin
                    pass_cnt++;
                end
            end
            if (aborted || (k == exp_pc.size() - 1) || (exp_grp[k + 1] != g)) begin
                $display("Test %s finished with %0d errors", grp_name[g], grp_fail[g]);
            end
        end

        $display("Checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- core_top.sv
`default_nettype none

module core_top (
    input  wire logic              clk_i,
    input  wire logic              rst_ni,

    output core_pkg::addr_t        imem_addr_o,
    input  wire core_pkg::instr_t  imem_data_i,

    output core_pkg::addr_t        pc_debug_o,
    output logic                   insn_vld_o,
    output logic                   wb_wren_o,
    output core_pkg::reg_idx_t     wb_rd_o,
    output core_pkg::word_t        wb_data_o
);
    import core_pkg::*;

    logic   if_valid;
    addr_t  if_pc;
    instr_t if_instr;

    logic   redirect_valid;
    addr_t  redirect_pc;

    id_ex_if id_ex ();

    fetch_stage u_fetch (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .redirect_valid_i (redirect_valid),
        .redirect_pc_i    (redirect_pc),
        .imem_addr_o      (imem_addr_o),
        .imem_data_i      (imem_data_i),
        .if_valid_o       (if_valid),
        .if_pc_o          (if_pc),
        .if_instr_o       (if_instr)
    );

    decode_stage u_decode (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .if_valid_i (if_valid),
        .if_pc_i    (if_pc),
        .if_instr_i (if_instr),
        .flush_i    (redirect_valid),
        .wb_wren_i  (wb_wren_o),
        .wb_rd_i    (wb_rd_o),
        .wb_data_i  (wb_data_o),
        .id_ex      (id_ex.stage_out)
    );

    execute_stage u_execute (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .id_ex            (id_ex.stage_in),
        .redirect_valid_o (redirect_valid),
        .redirect_pc_o    (redirect_pc),
        .wb_wren_o        (wb_wren_o),
        .wb_rd_o          (wb_rd_o),
        .wb_data_o        (wb_data_o),
        .pc_debug_o       (pc_debug_o),
        .insn_vld_o       (insn_vld_o)
    );

endmodule

`default_nettype wire

//--- execute_stage.sv
`default_nettype none

`include "core_cfg.svh"

module execute_stage (
    input  wire logic         clk_i,
    input  wire logic         rst_ni,

    id_ex_if.stage_in         id_ex,

    output logic              redirect_valid_o,
    output core_pkg::addr_t   redirect_pc_o,

    output logic              wb_wren_o,
    output core_pkg::reg_idx_t wb_rd_o,
    output core_pkg::word_t   wb_data_o,

    output core_pkg::addr_t   pc_debug_o,
    output logic              insn_vld_o
);
    import core_pkg::*;

    localparam int SHAMT_W = $clog2(`CORE_XLEN);

    fwd_sel_e rs1_fwd;
    fwd_sel_e rs2_fwd;
    word_t    rs1_val;
    word_t    rs2_val;
    word_t    op_a;
    word_t    op_b;
    word_t    alu_res;
    word_t    ex_result;
    addr_t    pc_plus4;
    logic     cond_taken;

    logic     exmem_valid;
    logic     exmem_rd_wren;
    reg_idx_t exmem_rd;
    word_t    exmem_result;
    addr_t    exmem_pc;

    logic     memwb_valid;
    logic     memwb_rd_wren;
    reg_idx_t memwb_rd;
    word_t    memwb_result;
    addr_t    memwb_pc;

    logic     exmem_fwd_en;
    logic     memwb_fwd_en;

    assign exmem_fwd_en = exmem_valid && exmem_rd_wren && (exmem_rd != '0);
    assign memwb_fwd_en = memwb_valid && memwb_rd_wren && (memwb_rd != '0);

    // Youngest producer wins
    function automatic fwd_sel_e fwd_src(reg_idx_t rs, logic ex_en, reg_idx_t ex_rd,
                                         logic wb_en, reg_idx_t wb_rd);
        if (ex_en && (ex_rd == rs)) begin
            return FWD_EXMEM;
        end
        if (wb_en && (wb_rd == rs)) begin
            return FWD_MEMWB;
        end
        return FWD_RF;
    endfunction

    function automatic word_t fwd_mux(fwd_sel_e sel, word_t rf_val, word_t ex_val,
                                      word_t wb_val);
        case (sel)
            FWD_EXMEM: return ex_val;
            FWD_MEMWB: return wb_val;
            default:   return rf_val;
        endcase
    endfunction

    assign rs1_fwd = fwd_src(id_ex.rs1, exmem_fwd_en, exmem_rd, memwb_fwd_en, memwb_rd);
    assign rs2_fwd = fwd_src(id_ex.rs2, exmem_fwd_en, exmem_rd, memwb_fwd_en, memwb_rd);
    assign rs1_val = fwd_mux(rs1_fwd, id_ex.rs1_data, exmem_result, memwb_result);
    assign rs2_val = fwd_mux(rs2_fwd, id_ex.rs2_data, exmem_result, memwb_result);

    assign op_a = (id_ex.opa_sel == OPA_PC)  ? id_ex.pc  : rs1_val;
    assign op_b = (id_ex.opb_sel == OPB_IMM) ? id_ex.imm : rs2_val;

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD:  alu_res = op_a + op_b;
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_SLL:  alu_res = op_a << op_b[SHAMT_W-1:0];
            ALU_SLT:  alu_res = {{(`CORE_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_res = {{(`CORE_XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SRL:  alu_res = op_a >> op_b[SHAMT_W-1:0];
            ALU_SRA:  alu_res = word_t'($signed(op_a) >>> op_b[SHAMT_W-1:0]);
            ALU_OR:   alu_res = op_a | op_b;
            ALU_AND:  alu_res = op_a & op_b;
            default:  alu_res = op_b;
        endcase
    end

    // Jumps link the return address instead of the ALU value
    assign pc_plus4  = id_ex.pc + addr_t'(4);
    assign ex_result = (id_ex.is_jal || id_ex.is_jalr) ? pc_plus4 : alu_res;

    // Branch condition on the forwarded register values
    always_comb begin
        case (id_ex.funct3)
            3'b000:  cond_taken = (rs1_val == rs2_val);
            3'b001:  cond_taken = (rs1_val != rs2_val);
            3'b100:  cond_taken = ($signed(rs1_val) < $signed(rs2_val));
            3'b101:  cond_taken = ($signed(rs1_val) >= $signed(rs2_val));
            3'b110:  cond_taken = (rs1_val < rs2_val);
            3'b111:  cond_taken = (rs1_val >= rs2_val);
            default: cond_taken = 1'b0;
        endcase
    end

    assign redirect_valid_o = id_ex.valid &&
                              (id_ex.is_jal || id_ex.is_jalr ||
                               (id_ex.is_branch && cond_taken));

    // JALR target has bit 0 forced low
    always_comb begin
        if (id_ex.is_jalr) begin
            redirect_pc_o = (rs1_val + id_ex.imm) & ~addr_t'(1);
        end else begin
            redirect_pc_o = id_ex.pc + id_ex.imm;
        end
    end

    // EX/MEM
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            exmem_valid   <= 1'b0;
            exmem_rd_wren <= 1'b0;
        end else begin
            exmem_valid   <= id_ex.valid;
            exmem_rd_wren <= id_ex.valid && id_ex.rd_wren;
        end
    end

    always_ff @(posedge clk_i) begin
        exmem_rd     <= id_ex.rd;
        exmem_result <= ex_result;
        exmem_pc     <= id_ex.pc;
    end

    // MEM/WB, nothing left to do in MEM without loads
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            memwb_valid   <= 1'b0;
            memwb_rd_wren <= 1'b0;
        end else begin
            memwb_valid   <= exmem_valid;
            memwb_rd_wren <= exmem_rd_wren;
        end
    end

    always_ff @(posedge clk_i) begin
        memwb_rd     <= exmem_rd;
        memwb_result <= exmem_result;
        memwb_pc     <= exmem_pc;
    end

    // Retire and write-back
    assign insn_vld_o = memwb_valid;
    assign pc_debug_o = memwb_pc;
    assign wb_wren_o  = memwb_rd_wren;
    assign wb_rd_o    = memwb_rd;
    assign wb_data_o  = memwb_result;

endmodule

`default_nettype wire

//--- decode_stage.sv
`default_nettype none

`include "core_cfg.svh"

module decode_stage (
    input  wire logic              clk_i,
    input  wire logic              rst_ni,

    input  wire logic              if_valid_i,
    input  wire core_pkg::addr_t   if_pc_i,
    input  wire core_pkg::instr_t  if_instr_i,

    input  wire logic              flush_i,

    input  wire logic              wb_wren_i,
    input  wire core_pkg::reg_idx_t wb_rd_i,
    input  wire core_pkg::word_t   wb_data_i,

    id_ex_if.stage_out             id_ex
);
    import core_pkg::*;

    logic [6:0] opcode;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    funct3_t    funct3;
    logic       funct7_alt;

    word_t      imm_i;
    word_t      imm_u;
    word_t      imm_b;
    word_t      imm_j;

    logic       legal;
    logic       writes_rd;
    alu_op_e    alu_op;
    opa_sel_e   opa_sel;
    opb_sel_e   opb_sel;
    logic       is_branch;
    logic       is_jal;
    logic       is_jalr;
    word_t      imm;

    word_t      rf_q [`CORE_NREGS];
    word_t      rs1_data;
    word_t      rs2_data;

    assign opcode     = if_instr_i[6:0];
    assign rd         = if_instr_i[11:7];
    assign funct3     = if_instr_i[14:12];
    assign rs1        = if_instr_i[19:15];
    assign rs2        = if_instr_i[24:20];
    assign funct7_alt = if_instr_i[30];

    assign imm_i = {{20{if_instr_i[31]}}, if_instr_i[31:20]};
    assign imm_u = {if_instr_i[31:12], 12'b0};
    assign imm_b = {{19{if_instr_i[31]}}, if_instr_i[31], if_instr_i[7],
                    if_instr_i[30:25], if_instr_i[11:8], 1'b0};
    assign imm_j = {{11{if_instr_i[31]}}, if_instr_i[31], if_instr_i[19:12],
                    if_instr_i[20], if_instr_i[30:21], 1'b0};

    // funct3 to ALU op, alt picks SUB or SRA
    function automatic alu_op_e funct_to_alu(funct3_t f3, logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        legal     = 1'b1;
        writes_rd = 1'b0;
        alu_op    = ALU_ADD;
        opa_sel   = OPA_RS1;
        opb_sel   = OPB_RS2;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        is_jalr   = 1'b0;
        imm       = imm_i;
        case (opcode)
            OPC_OP: begin
                writes_rd = 1'b1;
                alu_op    = funct_to_alu(funct3, funct7_alt);
            end
            OPC_OP_IMM: begin
                writes_rd = 1'b1;
                opb_sel   = OPB_IMM;
                // Only SRAI takes the alternate encoding among immediates
                alu_op    = funct_to_alu(funct3, funct7_alt && (funct3 == 3'b101));
            end
            OPC_LUI: begin
                writes_rd = 1'b1;
                opb_sel   = OPB_IMM;
                alu_op    = ALU_PASS_B;
                imm       = imm_u;
            end
            OPC_AUIPC: begin
                writes_rd = 1'b1;
                opa_sel   = OPA_PC;
                opb_sel   = OPB_IMM;
                imm       = imm_u;
            end
            OPC_BRANCH: begin
                is_branch = 1'b1;
                imm       = imm_b;
            end
            OPC_JAL: begin
                writes_rd = 1'b1;
                is_jal    = 1'b1;
                imm       = imm_j;
            end
            OPC_JALR: begin
                writes_rd = 1'b1;
                is_jalr   = 1'b1;
            end
            default: legal = 1'b0;
        endcase
    end

    // Register file, x0 is never stored
    always_ff @(posedge clk_i) begin
        if (wb_wren_i && (wb_rd_i != '0)) begin
            rf_q[wb_rd_i] <= wb_data_i;
        end
    end

    // Read with write-through from the retiring instruction
    function automatic word_t rf_read(reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (wb_wren_i && (wb_rd_i == idx)) begin
            return wb_data_i;
        end
        return rf_q[idx];
    endfunction

    always_comb begin
        rs1_data = rf_read(rs1);
        rs2_data = rf_read(rs2);
    end

    // ID/EX control, a bubble on flush or illegal opcode
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            id_ex.valid     <= 1'b0;
            id_ex.rd_wren   <= 1'b0;
            id_ex.is_branch <= 1'b0;
            id_ex.is_jal    <= 1'b0;
            id_ex.is_jalr   <= 1'b0;
        end else if (flush_i || !if_valid_i || !legal) begin
            id_ex.valid     <= 1'b0;
            id_ex.rd_wren   <= 1'b0;
            id_ex.is_branch <= 1'b0;
            id_ex.is_jal    <= 1'b0;
            id_ex.is_jalr   <= 1'b0;
        end else begin
            id_ex.valid     <= 1'b1;
            id_ex.rd_wren   <= writes_rd && (rd != '0);
            id_ex.is_branch <= is_branch;
            id_ex.is_jal    <= is_jal;
            id_ex.is_jalr   <= is_jalr;
        end
    end

    // ID/EX payload
    always_ff @(posedge clk_i) begin
        id_ex.pc       <= if_pc_i;
        id_ex.rs1      <= rs1;
        id_ex.rs2      <= rs2;
        id_ex.rd       <= rd;
        id_ex.rs1_data <= rs1_data;
        id_ex.rs2_data <= rs2_data;
        id_ex.imm      <= imm;
        id_ex.alu_op   <= alu_op;
        id_ex.opa_sel  <= opa_sel;
        id_ex.opb_sel  <= opb_sel;
        id_ex.funct3   <= funct3;
    end

endmodule

`default_nettype wire

//--- fetch_stage.sv
`default_nettype none

`include "core_cfg.svh"

module fetch_stage (
    input  wire logic            clk_i,
    input  wire logic            rst_ni,

    input  wire logic            redirect_valid_i,
    input  wire core_pkg::addr_t redirect_pc_i,

    output core_pkg::addr_t      imem_addr_o,
    input  wire core_pkg::instr_t imem_data_i,

    output logic                 if_valid_o,
    output core_pkg::addr_t      if_pc_o,
    output core_pkg::instr_t     if_instr_o
);
    import core_pkg::*;

    addr_t pc_q;
    addr_t pc_next;

    // Static not-taken, only a resolved branch or jump changes the flow
    always_comb begin
        if (redirect_valid_i) begin
            pc_next = redirect_pc_i;
        end else begin
            pc_next = pc_q + addr_t'(4);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pc_q <= addr_t'(`CORE_RESET_PC);
        end else begin
            pc_q <= pc_next;
        end
    end

    // Instruction memory answers in the same cycle
    assign imem_addr_o = pc_q;

    // IF/ID valid, dropped when EX redirects the younger fetch
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            if_valid_o <= 1'b0;
        end else begin
            if_valid_o <= !redirect_valid_i;
        end
    end

    // IF/ID payload
    always_ff @(posedge clk_i) begin
        if_pc_o    <= pc_q;
        if_instr_o <= imem_data_i;
    end

endmodule

`default_nettype wire

//--- id_ex_if.sv
`default_nettype none

interface id_ex_if;
    import core_pkg::*;

    logic      valid;
    addr_t     pc;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    reg_idx_t  rd;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     imm;
    alu_op_e   alu_op;
    opa_sel_e  opa_sel;
    opb_sel_e  opb_sel;
    funct3_t   funct3;
    logic      is_branch;
    logic      is_jal;
    logic      is_jalr;
    logic      rd_wren;

    modport stage_out (
        output valid, pc, rs1, rs2, rd, rs1_data, rs2_data, imm, alu_op,
               opa_sel, opb_sel, funct3, is_branch, is_jal, is_jalr, rd_wren
    );

    modport stage_in (
        input valid, pc, rs1, rs2, rd, rs1_data, rs2_data, imm, alu_op,
              opa_sel, opb_sel, funct3, is_branch, is_jal, is_jalr, rd_wren
    );

endinterface

`default_nettype wire

//--- core_pkg.sv
`default_nettype none

`include "core_cfg.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0] word_t;
    typedef logic [`CORE_XLEN-1:0] addr_t;
    typedef logic [`CORE_ILEN-1:0] instr_t;
    typedef logic [$clog2(`CORE_NREGS)-1:0] reg_idx_t;
    typedef logic [2:0] funct3_t;

    // Major opcodes handled by this core, anything else is illegal
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic {
        OPA_RS1,
        OPA_PC
    } opa_sel_e;

    typedef enum logic {
        OPB_RS2,
        OPB_IMM
    } opb_sel_e;

    // Where an EX operand comes from
    typedef enum logic [1:0] {
        FWD_RF    = 2'b00,
        FWD_EXMEM = 2'b01,
        FWD_MEMWB = 2'b10
    } fwd_sel_e;

endpackage

`default_nettype wire

//--- core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Datapath width in bits
`define CORE_XLEN 32

// Architectural integer registers, x0 included
`define CORE_NREGS 32

// First fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

// Instruction word width
`define CORE_ILEN 32

`endif
